//--- build.f
src/psram_pkg.sv
src/psram_request_latch.sv
src/psram_burst_sequencer.sv
src/psram_pin_driver.sv
src/psram_subsystem.sv
tests/psram_model.sv
tests/psram_tb.sv

//--- Bender.yml
package:
  name: psram_subsystem

sources:
  - src/psram_pkg.sv
  - src/psram_request_latch.sv
  - src/psram_burst_sequencer.sv
  - src/psram_pin_driver.sv
  - src/psram_subsystem.sv
  - target: test
    files:
      - tests/psram_model.sv
      - tests/psram_tb.sv

//--- tests/psram_tb.sv
`timescale 1ns/10ps
`default_nettype none

module psram_tb;

    localparam int a_width    = 24;
    localparam int d_width    = 16;
    localparam int bus_width  = 32;
    localparam int bus_ctrl   = 8;
    localparam int rw_latency = 3;
    localparam int depth      = 1024;
    localparam int num_req    = 40;
    localparam int clk_period = 20;
    // Longest request is accept, latency, 8 beats, finish, one hold and the drop cycle
    localparam int timeout_cycles = num_req * (rw_latency + 8 + 4) + 100;

    logic                 clk50MHz;
    logic                 arst_n;
    logic                 bus_ack;
    logic                 mwait;
    logic [bus_ctrl-1:0]  bus_ctrl_in;
    logic [bus_ctrl-1:0]  bus_ctrl_out;
    logic [bus_width-1:0] bus_data_in;
    logic [bus_width-1:0] bus_data_out;
    logic [a_width-1:0]   maddr;
    logic                 moe_n;
    logic                 mwe_n;
    logic                 madv_n;
    logic                 mclk;
    logic                 mce_n;
    logic                 mub_n;
    logic                 mlb_n;
    logic                 mcre;
    wire  [d_width-1:0]   mem_data;

    logic [d_width-1:0] ref_mem [0:depth-1];
    integer             seed;
    int                 errors;
    int                 checks;
    int                 tests;
    int                 test_errors;

    psram_subsystem #(
        .a_width    (a_width),
        .d_width    (d_width),
        .bus_width  (bus_width),
        .bus_ctrl   (bus_ctrl),
        .rw_latency (rw_latency)
    ) u_psram_subsystem (
        .clk50MHz     (clk50MHz),
        .arst_n       (arst_n),
        .bus_ack      (bus_ack),
        .bus_ctrl_in  (bus_ctrl_in),
        .bus_ctrl_out (bus_ctrl_out),
        .bus_data_in  (bus_data_in),
        .bus_data_out (bus_data_out),
        .mem_data     (mem_data),
        .maddr        (maddr),
        .moe_n        (moe_n),
        .mwe_n        (mwe_n),
        .madv_n       (madv_n),
        .mclk         (mclk),
        .mub_n        (mub_n),
        .mlb_n        (mlb_n),
        .mce_n        (mce_n),
        .mcre         (mcre),
        .mwait        (mwait)
    );

    psram_model #(
        .a_width    (a_width),
        .d_width    (d_width),
        .rw_latency (rw_latency),
        .depth      (depth)
    ) u_psram_model (
        .mclk     (mclk),
        .mce_n    (mce_n),
        .madv_n   (madv_n),
        .mwe_n    (mwe_n),
        .moe_n    (moe_n),
        .maddr    (maddr),
        .mem_data (mem_data)
    );

    initial begin
        clk50MHz = 1'b0;
        forever #(clk_period / 2) clk50MHz = ~clk50MHz;
    end

    initial begin
        #(timeout_cycles * clk_period);
        $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic compare_value(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, sig, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    // Codes 0 to 3 double the length each step, the rest run one word
    function automatic int beats_for_code(input logic [2:0] code);
        if (code <= psram_pkg::burst_8) begin
            return 1 << code;
        end else begin
            return 1;
        end
    endfunction

    task automatic check_reset_state();
        test_errors = 0;
        @(posedge clk50MHz);
        // Middle of the high phase, a running mclk would show here
        #(clk_period / 4);
        compare_value("mce_n", mce_n, 1);
        compare_value("madv_n", madv_n, 1);
        compare_value("mwe_n", mwe_n, 1);
        compare_value("moe_n", moe_n, 1);
        compare_value("mclk", mclk, 0);
        compare_value("mub_n", mub_n, 0);
        compare_value("mlb_n", mlb_n, 0);
        compare_value("mcre", mcre, 0);
        compare_value("bus_ctrl_out", bus_ctrl_out, 0);
        compare_value("mem_data", {16'h0, mem_data}, {16'h0, {d_width{1'bz}}});
        tests++;
        $display("Test reset state: %s", (test_errors == 0) ? "pass" : "fail");
    endtask

    task automatic run_request(input int n, input logic we, input logic [2:0] code,
                               input int addr, input int hold);
        logic [bus_width-1:0] wdata [0:7];
        logic [bus_ctrl-1:0]  ctrl;
        int                   beats;
        int                   idx;

        test_errors = 0;
        beats = beats_for_code(code);
        for (int j = 0; j < 8; j++) begin
            wdata[j] = $random(seed);
        end
        ctrl = '0;
        ctrl[psram_pkg::ctrl_we_bit] = we;
        ctrl[psram_pkg::ctrl_burst_lsb +: 3] = code;

        // Accept cycle
        @(posedge clk50MHz);
        bus_ack     <= 1'b1;
        bus_ctrl_in <= ctrl;
        bus_data_in <= bus_width'(addr);
        #(clk_period / 4);
        compare_value("mclk", mclk, 0);
        @(negedge clk50MHz);
        compare_value("madv_n", madv_n, 0);
        compare_value("mce_n", mce_n, 0);
        compare_value("mwe_n", mwe_n, !we);
        compare_value("maddr", maddr, addr);
        compare_value("mub_n", mub_n, 0);
        compare_value("mlb_n", mlb_n, 0);
        compare_value("mcre", mcre, 0);
        compare_value("bus_ctrl_out", bus_ctrl_out, 0);

        // Wait states, data beats and the first finish cycle
        for (int c = 1; c <= rw_latency + beats + 1; c++) begin
            idx = c - rw_latency - 1;
            @(posedge clk50MHz);
            if (idx >= 0 && idx < beats) begin
                bus_data_in <= wdata[idx];
                if (we) begin
                    ref_mem[addr + idx] = wdata[idx][d_width-1:0];
                end
            end else begin
                bus_data_in <= $random(seed);
            end
            #(clk_period / 4);
            compare_value("mclk", mclk, 1);
            @(negedge clk50MHz);
            compare_value("bus_ctrl_out", bus_ctrl_out,
                          (c <= rw_latency) ? (1 << psram_pkg::ctrl_wait_bit) : 0);
            compare_value("mce_n", mce_n, idx == beats);
            compare_value("madv_n", madv_n, 1);
            compare_value("maddr", maddr, addr);
            compare_value("moe_n", moe_n, !(!we && idx >= 0 && idx < beats));
            if (!we && idx >= 1) begin
                compare_value("bus_data_out", bus_data_out, {16'h0, ref_mem[addr + idx - 1]});
            end
        end

        // Host holds its acknowledge in finish
        for (int c = 0; c < hold; c++) begin
            @(posedge clk50MHz);
            #(clk_period / 4);
            compare_value("mclk", mclk, 1);
            @(negedge clk50MHz);
            compare_value("mce_n", mce_n, 1);
            compare_value("madv_n", madv_n, 1);
        end
        @(posedge clk50MHz);
        bus_ack <= 1'b0;
        @(negedge clk50MHz);
        compare_value("mce_n", mce_n, 1);

        // Burst words plus the word after it, which must be untouched
        for (int j = 0; j <= beats; j++) begin
            compare_value("model word", u_psram_model.mem[addr + j], ref_mem[addr + j]);
        end
        tests++;
        $display("Test %0d %s code %0d addr %h beats %0d: %s", n, we ? "write" : "read",
                 code, addr, beats, (test_errors == 0) ? "pass" : "fail");
    endtask

    task automatic compare_memories();
        test_errors = 0;
        for (int i = 0; i < depth; i++) begin
            compare_value("model word", u_psram_model.mem[i], ref_mem[i]);
        end
        tests++;
        $display("Test memory contents: %s", (test_errors == 0) ? "pass" : "fail");
    endtask

    initial begin
        logic       we;
        logic [2:0] code;
        int         addr;
        int         hold;

        seed        = 32'h266a;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        arst_n      = 1'b0;
        bus_ack     = 1'b0;
        mwait       = 1'b0;
        bus_ctrl_in = '0;
        bus_data_in = '0;
        for (int i = 0; i < depth; i++) begin
            ref_mem[i] = d_width'(i) ^ d_width'(16'ha5a5);
        end

        repeat (16) @(posedge clk50MHz);
        arst_n <= 1'b1;
        check_reset_state();

        // Every code written first, then read, then random traffic
        for (int n = 0; n < num_req; n++) begin
            if (n < 16) begin
                we   = (n < 8);
                code = 3'(n % 8);
            end else begin
                we   = $random(seed);
                code = $random(seed);
            end
            addr = $random(seed) & 255;
            hold = $random(seed) & 1;
            run_request(n, we, code, addr, hold);
        end
        compare_memories();

        $display("Tests run %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/psram_model.sv
`timescale 1ns/10ps
`default_nettype none

module psram_model #(
    parameter int a_width    = 24,
    parameter int d_width    = 16,
    parameter int rw_latency = 3,
    parameter int depth      = 1024
) (
    input  wire                mclk,
    input  wire                mce_n,
    input  wire                madv_n,
    input  wire                mwe_n,
    input  wire                moe_n,
    input  wire  [a_width-1:0] maddr,
    inout  wire  [d_width-1:0] mem_data
);

    localparam int idx_w = $clog2(depth);

    logic [d_width-1:0] mem [0:depth-1];
    logic [idx_w-1:0]   addr_q;
    logic [d_width-1:0] rd_word;
    logic               we_q;
    logic               active;
    logic               in_data;
    int                 lat_cnt;

    // Unwritten words follow the address pattern
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = d_width'(i) ^ d_width'(16'ha5a5);
        end
        addr_q  = '0;
        rd_word = '0;
        we_q    = 1'b0;
        active  = 1'b0;
        in_data = 1'b0;
        lat_cnt = 0;
    end

    assign mem_data = (!moe_n && in_data) ? rd_word : {d_width{1'bz}};

    always @(posedge mclk) begin
        if (!madv_n && !mce_n) begin
            // Address phase, start of a new burst
            addr_q  <= maddr[idx_w-1:0];
            we_q    <= !mwe_n;
            active  <= 1'b1;
            in_data <= 1'b0;
            lat_cnt <= 0;
        end else if (mce_n) begin
            active  <= 1'b0;
            in_data <= 1'b0;
        end else if (active && !in_data) begin
            if (lat_cnt == rw_latency - 1) begin
                in_data <= 1'b1;
                rd_word <= mem[addr_q];
            end
            lat_cnt <= lat_cnt + 1;
        end else if (in_data) begin
            if (we_q) begin
                mem[addr_q] <= mem_data;
            end
            // Internal address counter
            addr_q  <= addr_q + 1'b1;
            rd_word <= mem[addr_q + 1'b1];
        end
    end

endmodule

`default_nettype wire

//--- src/psram_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module psram_subsystem #(
    parameter int a_width    = 24,
    parameter int d_width    = 16,
    parameter int bus_width  = 32,
    parameter int bus_ctrl   = 8,
    parameter int rw_latency = 3
) (
    input  wire                  clk50MHz,
    input  wire                  arst_n,
    input  wire                  bus_ack,
    input  wire  [bus_ctrl-1:0]  bus_ctrl_in,
    output logic [bus_ctrl-1:0]  bus_ctrl_out,
    input  wire  [bus_width-1:0] bus_data_in,
    output logic [bus_width-1:0] bus_data_out,
    inout  wire  [d_width-1:0]   mem_data,
    output logic [a_width-1:0]   maddr,
    output logic                 moe_n,
    output logic                 mwe_n,
    output logic                 madv_n,
    output logic                 mclk,
    output logic                 mub_n,
    output logic                 mlb_n,
    output logic                 mce_n,
    output logic                 mcre,
    // Fixed latency mode, device wait is not used
    input  wire                  mwait
);

    logic       accept;
    logic       write;
    logic       write_req;
    logic [3:0] burst_beats;
    logic       idle;
    logic       wait_flag;
    logic       beat;
    logic       oe_n;
    logic       mclk_en;

    // Raw direction bit for the accept cycle
    assign write_req = bus_ctrl_in[psram_pkg::ctrl_we_bit];

    always_comb begin
        bus_ctrl_out = '0;
        bus_ctrl_out[psram_pkg::ctrl_wait_bit] = wait_flag;
    end

    // Both bytes always enabled, configuration register never selected
    assign mub_n = 1'b0;
    assign mlb_n = 1'b0;
    assign mcre  = 1'b0;

    psram_request_latch #(
        .a_width   (a_width),
        .bus_width (bus_width),
        .bus_ctrl  (bus_ctrl)
    ) u_psram_request_latch (
        .clk50MHz    (clk50MHz),
        .arst_n      (arst_n),
        .bus_ack     (bus_ack),
        .idle        (idle),
        .bus_ctrl_in (bus_ctrl_in),
        .bus_data_in (bus_data_in),
        .accept      (accept),
        .write       (write),
        .burst_beats (burst_beats),
        .maddr       (maddr)
    );

    psram_burst_sequencer #(
        .rw_latency (rw_latency)
    ) u_psram_burst_sequencer (
        .clk50MHz    (clk50MHz),
        .arst_n      (arst_n),
        .bus_ack     (bus_ack),
        .accept      (accept),
        .write       (write),
        .write_req   (write_req),
        .burst_beats (burst_beats),
        .idle        (idle),
        .wait_flag   (wait_flag),
        .beat        (beat),
        .mce_n       (mce_n),
        .madv_n      (madv_n),
        .mwe_n       (mwe_n),
        .oe_n        (oe_n),
        .mclk_en     (mclk_en)
    );

    psram_pin_driver #(
        .d_width   (d_width),
        .bus_width (bus_width)
    ) u_psram_pin_driver (
        .clk50MHz     (clk50MHz),
        .arst_n       (arst_n),
        .mclk_en      (mclk_en),
        .beat         (beat),
        .write        (write),
        .oe_n         (oe_n),
        .bus_data_in  (bus_data_in),
        .bus_data_out (bus_data_out),
        .mem_data     (mem_data),
        .mclk         (mclk),
        .moe_n        (moe_n)
    );

endmodule

`default_nettype wire

//--- src/psram_pin_driver.sv
`timescale 1ns/10ps
`default_nettype none

module psram_pin_driver #(
    parameter int d_width   = 16,
    parameter int bus_width = 32
) (
    input  wire                  clk50MHz,
    input  wire                  arst_n,
    input  wire                  mclk_en,
    input  wire                  beat,
    input  wire                  write,
    input  wire                  oe_n,
    input  wire  [bus_width-1:0] bus_data_in,
    output logic [bus_width-1:0] bus_data_out,
    inout  wire  [d_width-1:0]   mem_data,
    output logic                 mclk,
    output logic                 moe_n
);

    logic clk_en_q;
    logic drive_en;
    logic capture_en;

    // Write beats only, the bus floats the rest of the time
    assign drive_en = beat & write;

    assign mem_data = drive_en ? bus_data_in[d_width-1:0] : {d_width{1'bz}};

    // Device drives the bus while its output enable is low
    assign moe_n = oe_n;

    assign capture_en = beat & ~oe_n;

    // Read word at the end of the beat, upper bits zero
    always_ff @(posedge clk50MHz) begin
        if (capture_en) begin
            bus_data_out <= bus_width'(mem_data);
        end
    end

    // Enable changes only while clk50MHz is low
    always_ff @(negedge clk50MHz or negedge arst_n) begin
        if (!arst_n) begin
            clk_en_q <= 1'b0;
        end else begin
            clk_en_q <= mclk_en;
        end
    end

    assign mclk = clk50MHz & clk_en_q;

endmodule

`default_nettype wire

//--- src/psram_burst_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module psram_burst_sequencer #(
    parameter int rw_latency = 3
) (
    input  wire        clk50MHz,
    input  wire        arst_n,
    input  wire        bus_ack,
    input  wire        accept,
    input  wire        write,
    input  wire        write_req,
    input  wire  [3:0] burst_beats,
    output logic       idle,
    output logic       wait_flag,
    output logic       beat,
    output logic       mce_n,
    output logic       madv_n,
    output logic       mwe_n,
    output logic       oe_n,
    output logic       mclk_en
);

    localparam int lat_w = (rw_latency > 1) ? $clog2(rw_latency) : 1;
    localparam logic [lat_w-1:0] lat_last = lat_w'(rw_latency - 1);

    psram_pkg::seq_state_t state;
    psram_pkg::seq_state_t state_next;

    logic [lat_w-1:0] lat_cnt;
    logic [3:0]       beat_cnt;
    logic             lat_done;
    logic             burst_done;
    logic             in_wait;
    logic             in_data;

    assign in_wait = (state == psram_pkg::read_wait) || (state == psram_pkg::write_wait);
    assign in_data = (state == psram_pkg::read_data) || (state == psram_pkg::write_data);

    assign lat_done   = (lat_cnt == lat_last);
    assign burst_done = (beat_cnt == burst_beats - 4'd1);

    always_ff @(posedge clk50MHz or negedge arst_n) begin
        if (!arst_n) begin
            state <= psram_pkg::idle;
        end else begin
            state <= state_next;
        end
    end

    // Latency counter, runs only through the wait states
    always_ff @(posedge clk50MHz or negedge arst_n) begin
        if (!arst_n) begin
            lat_cnt <= '0;
        end else if (in_wait) begin
            lat_cnt <= lat_cnt + 1'b1;
        end else begin
            lat_cnt <= '0;
        end
    end

    // Beat counter, runs only through the data states
    always_ff @(posedge clk50MHz or negedge arst_n) begin
        if (!arst_n) begin
            beat_cnt <= 4'd0;
        end else if (in_data) begin
            beat_cnt <= beat_cnt + 4'd1;
        end else begin
            beat_cnt <= 4'd0;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            psram_pkg::idle: begin
                // Direction from the control byte as it is on the bus now
                if (accept) begin
                    if (write_req) begin
                        state_next = psram_pkg::write_wait;
                    end else begin
                        state_next = psram_pkg::read_wait;
                    end
                end
            end
            psram_pkg::read_wait,
            psram_pkg::write_wait: begin
                // Latched flag is valid from here on
                if (lat_done) begin
                    if (write) begin
                        state_next = psram_pkg::write_data;
                    end else begin
                        state_next = psram_pkg::read_data;
                    end
                end
            end
            psram_pkg::read_data,
            psram_pkg::write_data: begin
                if (burst_done) begin
                    state_next = psram_pkg::finish;
                end
            end
            psram_pkg::finish: begin
                // Host must drop its acknowledge before another request
                if (!bus_ack) begin
                    state_next = psram_pkg::idle;
                end
            end
            default: begin
                state_next = psram_pkg::idle;
            end
        endcase
    end

    always_comb begin
        idle      = (state == psram_pkg::idle);
        wait_flag = in_wait;
        beat      = in_data;
        oe_n      = (state != psram_pkg::read_data);

        // Address phase in the accept cycle
        madv_n = !(idle && accept);
        mwe_n  = !(idle && accept && write_req);

        if (idle) begin
            mce_n = !accept;
        end else begin
            mce_n = (state == psram_pkg::finish);
        end

        // Looks one cycle ahead, the pin driver samples it on the falling edge
        mclk_en = (state_next != psram_pkg::idle);
    end

endmodule

`default_nettype wire

//--- src/psram_request_latch.sv
`timescale 1ns/10ps
`default_nettype none

module psram_request_latch #(
    parameter int a_width   = 24,
    parameter int bus_width = 32,
    parameter int bus_ctrl  = 8
) (
    input  wire                  clk50MHz,
    input  wire                  arst_n,
    input  wire                  bus_ack,
    input  wire                  idle,
    input  wire  [bus_ctrl-1:0]  bus_ctrl_in,
    input  wire  [bus_width-1:0] bus_data_in,
    output logic                 accept,
    output logic                 write,
    output logic [3:0]           burst_beats,
    output logic [a_width-1:0]   maddr
);

    psram_pkg::burst_code_t burst_code;
    logic [3:0]             beats_dec;
    logic [a_width-1:0]     maddr_q;

    // Request is only taken while the sequencer sits in idle
    assign accept = bus_ack & idle;

    // Burst code to number of words
    always_comb begin
        burst_code = psram_pkg::burst_code_t'(
            bus_ctrl_in[psram_pkg::ctrl_burst_lsb +: $bits(psram_pkg::burst_code_t)]);
        case (burst_code)
            psram_pkg::burst_1: beats_dec = 4'd1;
            psram_pkg::burst_2: beats_dec = 4'd2;
            psram_pkg::burst_4: beats_dec = 4'd4;
            psram_pkg::burst_8: beats_dec = 4'd8;
            default:            beats_dec = 4'd1;
        endcase
    end

    always_ff @(posedge clk50MHz or negedge arst_n) begin
        if (!arst_n) begin
            write       <= 1'b0;
            burst_beats <= 4'd1;
        end else if (accept) begin
            write       <= bus_ctrl_in[psram_pkg::ctrl_we_bit];
            burst_beats <= beats_dec;
        end
    end

    // Start address only, the device counts through the burst itself
    always_ff @(posedge clk50MHz) begin
        if (accept) begin
            maddr_q <= bus_data_in[a_width-1:0];
        end
    end

    // Device latches the address while address valid is low
    assign maddr = accept ? bus_data_in[a_width-1:0] : maddr_q;

endmodule

`default_nettype wire

//--- src/psram_pkg.sv
`default_nettype none

package psram_pkg;

    // Host control byte, request direction
    localparam int ctrl_we_bit = 1;

    // Lowest bit of the 3-bit burst code field
    localparam int ctrl_burst_lsb = 2;

    // Host control byte, response direction
    localparam int ctrl_wait_bit = 0;

    // Burst length codes, anything above burst_8 runs a single word
    typedef enum logic [2:0] {
        burst_1 = 3'd0,
        burst_2 = 3'd1,
        burst_4 = 3'd2,
        burst_8 = 3'd3
    } burst_code_t;

    // Controller states
    typedef enum logic [2:0] {
        idle,
        read_wait,
        read_data,
        write_wait,
        write_data,
        finish
    } seq_state_t;

endpackage

`default_nettype wire
